//--- logic/list_mem_macros.svh
//------------------------------
// List storage sizing
// Depth, address and entry widths of the 32x14 list memory,
// plus the split of an entry into queue id and tag
//------------------------------
`ifndef LIST_MEM_MACROS_SVH
`define LIST_MEM_MACROS_SVH

// Number of entries held by the register file
`define LIST_DEPTH 32

// Address width, enough to index every entry
`define LIST_AW 5

// Stored word width
`define LIST_DW 14

// Entry fields, queue id on top and tag below
`define LIST_QID_W 5
`define LIST_TAG_W 9

`endif

//--- logic/list_mem_pkg.sv
//------------------------------
// List storage types
// Shared vector types for addresses, entries, entry fields
// and the occupancy count
//------------------------------
`include "list_mem_macros.svh"

package list_mem_pkg;

    // Register file address
    typedef logic [`LIST_AW-1:0] list_addr_t;

    // One stored word, queue id in the upper bits and tag in the lower bits
    typedef logic [`LIST_DW-1:0] list_entry_t;

    // Queue id field of an entry
    typedef logic [`LIST_QID_W-1:0] list_qid_t;

    // Tag field of an entry
    typedef logic [`LIST_TAG_W-1:0] list_tag_t;

    // Occupancy from 0 to LIST_DEPTH, one bit wider than an address
    typedef logic [`LIST_AW:0] list_cnt_t;

endpackage

//--- logic/list_enq.sv
//------------------------------
// List enqueue
// Packs incoming queue id and tag into an entry, writes it at the
// write pointer and keeps the list occupancy. Drops input when the
// list is full or the memory is asleep, and flushes on sleep
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_enq
    import list_mem_pkg::*;
(
     input  logic        clk
    ,input  logic        rst_n

    ,input  logic        enq_valid
    ,input  list_qid_t   enq_qid
    ,input  list_tag_t   enq_tag

    ,input  logic        deq_pop
    ,input  logic        pwr_ack_b

    ,output logic        wr_en
    ,output list_addr_t  wr_addr
    ,output list_entry_t wr_data

    ,output logic        enq_drop
    ,output logic        list_avail
    ,output logic        list_flush
    ,output list_cnt_t   list_count
);

    logic       enq_ok;
    logic       list_full;
    list_addr_t wr_ptr;

    //------------------------------
    // Accept and write

    // Full means every slot holds an entry not yet popped
    assign list_full  = (list_count == list_cnt_t'(`LIST_DEPTH));

    // The memory loses its contents while asleep, so the list is flushed
    assign list_flush = pwr_ack_b;

    // An entry is taken only with room left and the memory awake
    assign enq_ok     = enq_valid && !list_full && !pwr_ack_b;

    // The write goes to the array on the same edge that samples the request
    assign wr_en      = enq_ok;
    assign wr_addr    = wr_ptr;
    assign wr_data    = {enq_qid, enq_tag};

    // Something is there to read whenever the count is non-zero
    assign list_avail = (list_count != '0);

    // Write pointer wraps naturally at the address width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (list_flush) begin
            wr_ptr <= '0;
        end else if (enq_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //------------------------------
    // Occupancy and drop

    // An enqueue and a pop on the same edge cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            list_count <= '0;
        end else if (list_flush) begin
            list_count <= '0;
        end else begin
            case ({enq_ok, deq_pop})
                2'b10:   list_count <= list_count + 1'b1;
                2'b01:   list_count <= list_count - 1'b1;
                default: list_count <= list_count;
            endcase
        end
    end

    // Refused requests are reported one cycle after they were sampled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enq_drop <= 1'b0;
        end else begin
            enq_drop <= enq_valid && !enq_ok;
        end
    end

    //------------------------------
    // Checks

    // The count stays within the list depth
    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        list_count <= list_cnt_t'(`LIST_DEPTH));

    // The consumer never pops an empty list, so the count cannot wrap below zero
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        deq_pop |-> (list_count != '0));

endmodule

//--- logic/list_rf_pg_32x14.sv
//------------------------------
// Power gated 32x14 register file
// Storage array with synchronous write and registered read,
// a two flop ip reset synchronizer, a registered power enable
// acknowledge and output isolation
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_rf_pg_32x14
    import list_mem_pkg::*;
(
     input  logic        clk
    ,input  logic        rst_n

    ,input  logic        ip_reset_b

    ,input  logic        wr_en
    ,input  list_addr_t  wr_addr
    ,input  list_entry_t wr_data

    ,input  logic        rd_en
    ,input  list_addr_t  rd_addr
    ,output list_entry_t rd_data

    // Power interface
    ,input  logic        isol_en
    ,input  logic        pwr_enable_b
    ,output logic        pwr_ack_b
);

    logic        ip_rst_meta;
    logic        ip_rst_sync;
    list_entry_t mem [`LIST_DEPTH];
    list_entry_t rd_q;

    //------------------------------
    // Reset synchronizer

    // Two flops bring the ip reset into the clock domain
    // Both stages start low so the output stays quiet until the reset is released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ip_rst_meta <= 1'b0;
            ip_rst_sync <= 1'b0;
        end else begin
            ip_rst_meta <= ip_reset_b;
            ip_rst_sync <= ip_rst_meta;
        end
    end

    //------------------------------
    // Power acknowledge

    // The array follows the enable one cycle later
    // It comes out of reset asleep and wakes only once the enable is seen low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pwr_ack_b <= 1'b1;
        end else begin
            pwr_ack_b <= pwr_enable_b;
        end
    end

    //------------------------------
    // Storage array

    // Writes land only while the array is powered
    always_ff @(posedge clk) begin
        if (wr_en && !pwr_ack_b) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data is held until the next read
    // A read and a write to the same slot on one edge return the old word
    // Asleep, the read port has nothing valid to give
    always_ff @(posedge clk) begin
        if (pwr_ack_b) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    //------------------------------
    // Output isolation

    // Clamp to zero while isolated or while the array is still in ip reset
    assign rd_data = (isol_en || !ip_rst_sync) ? '0 : rd_q;

    //------------------------------
    // Checks

    // The producer must stop writing as soon as the array reports sleep
    a_no_write_asleep: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !pwr_ack_b);

endmodule

//--- logic/list_deq.sv
//------------------------------
// List dequeue
// Turns dequeue requests into reads of the oldest entry, then
// presents the entry fields with a valid pulse two cycles after
// the request. Requests on an empty list report underrun
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_deq
    import list_mem_pkg::*;
(
     input  logic        clk
    ,input  logic        rst_n

    ,input  logic        deq_req
    ,input  logic        list_avail
    ,input  logic        list_flush

    ,output logic        rd_en
    ,output list_addr_t  rd_addr
    ,input  list_entry_t rd_data

    ,output logic        deq_pop
    ,output logic        deq_valid
    ,output list_qid_t   deq_qid
    ,output list_tag_t   deq_tag
    ,output logic        deq_underrun
);

    list_addr_t rd_ptr;
    logic       rd_miss_q;
    logic       rd_pend_q;

    //------------------------------
    // Request accept

    // The pop goes back to the producer on the request edge, so the count
    // falls right away even though the read itself goes out a cycle later
    assign deq_pop = deq_req && list_avail;

    // Read pointer follows the pops and restarts on flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (list_flush) begin
            rd_ptr <= '0;
        end else if (deq_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Address of the slot being popped, held for the read
    always_ff @(posedge clk) begin
        if (deq_pop) begin
            rd_addr <= rd_ptr;
        end
    end

    //------------------------------
    // Read pipeline

    // Stage one issues the read or notes the miss
    // Stage two waits for the array to register its output
    // Stage three captures the entry and raises the valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_en        <= 1'b0;
            rd_miss_q    <= 1'b0;
            rd_pend_q    <= 1'b0;
            deq_underrun <= 1'b0;
            deq_valid    <= 1'b0;
        end else begin
            rd_en        <= deq_pop;
            rd_miss_q    <= deq_req && !list_avail;
            rd_pend_q    <= rd_en;
            deq_underrun <= rd_miss_q;
            deq_valid    <= rd_pend_q;
        end
    end

    // Split the captured word into queue id and tag
    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            {deq_qid, deq_tag} <= rd_data;
        end
    end

    //------------------------------
    // Checks

    // A flush leaves the producer with nothing to offer, matching the read pointer restart
    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        list_flush |=> !list_avail);

endmodule

//--- logic/list_mem_top.sv
//------------------------------
// List storage top
// Connects the enqueue block, the power gated register file and
// the dequeue block into one in-order list
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_mem_top
    import list_mem_pkg::*;
(
     input  logic        clk
    ,input  logic        rst_n

    // Producer side
    ,input  logic        enq_valid
    ,input  list_qid_t   enq_qid
    ,input  list_tag_t   enq_tag
    ,output logic        enq_drop

    // Consumer side
    ,input  logic        deq_req
    ,output logic        deq_valid
    ,output list_qid_t   deq_qid
    ,output list_tag_t   deq_tag
    ,output logic        deq_underrun

    // Power interface
    ,input  logic        pwr_enable_b
    ,output logic        pwr_ack_b
    ,input  logic        isol_en

    ,output list_cnt_t   list_count
);

    // Write port from the producer
    logic        wr_en;
    list_addr_t  wr_addr;
    list_entry_t wr_data;

    // Read port from the consumer
    logic        rd_en;
    list_addr_t  rd_addr;
    list_entry_t rd_data;

    // Handshake between producer and consumer
    logic        list_avail;
    logic        list_flush;
    logic        deq_pop;

    //------------------------------
    // Producer

    list_enq i_list_enq (
         .clk          (clk)
        ,.rst_n        (rst_n)
        ,.enq_valid    (enq_valid)
        ,.enq_qid      (enq_qid)
        ,.enq_tag      (enq_tag)
        ,.deq_pop      (deq_pop)
        ,.pwr_ack_b    (pwr_ack_b)
        ,.wr_en        (wr_en)
        ,.wr_addr      (wr_addr)
        ,.wr_data      (wr_data)
        ,.enq_drop     (enq_drop)
        ,.list_avail   (list_avail)
        ,.list_flush   (list_flush)
        ,.list_count   (list_count)
    );

    //------------------------------
    // Storage

    // The ip reset shares the system reset here
    list_rf_pg_32x14 i_rf (
         .clk          (clk)
        ,.rst_n        (rst_n)
        ,.ip_reset_b   (rst_n)
        ,.wr_en        (wr_en)
        ,.wr_addr      (wr_addr)
        ,.wr_data      (wr_data)
        ,.rd_en        (rd_en)
        ,.rd_addr      (rd_addr)
        ,.rd_data      (rd_data)
        ,.isol_en      (isol_en)
        ,.pwr_enable_b (pwr_enable_b)
        ,.pwr_ack_b    (pwr_ack_b)
    );

    //------------------------------
    // Consumer

    list_deq i_list_deq (
         .clk          (clk)
        ,.rst_n        (rst_n)
        ,.deq_req      (deq_req)
        ,.list_avail   (list_avail)
        ,.list_flush   (list_flush)
        ,.rd_en        (rd_en)
        ,.rd_addr      (rd_addr)
        ,.rd_data      (rd_data)
        ,.deq_pop      (deq_pop)
        ,.deq_valid    (deq_valid)
        ,.deq_qid      (deq_qid)
        ,.deq_tag      (deq_tag)
        ,.deq_underrun (deq_underrun)
    );

endmodule

//--- verification/list_mem_checker.sv
//------------------------------
// List storage checker
// Keeps a reference queue from the top-level inputs and compares
// count, drop, underrun, power acknowledge and read data
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_mem_checker
    import list_mem_pkg::*;
(
     input  logic        clk
    ,input  logic        rst_n
    ,input  logic        enq_valid
    ,input  list_qid_t   enq_qid
    ,input  list_tag_t   enq_tag
    ,input  logic        deq_req
    ,input  logic        pwr_enable_b
    ,input  logic        isol_en
    ,input  logic        enq_drop
    ,input  logic        deq_valid
    ,input  list_qid_t   deq_qid
    ,input  list_tag_t   deq_tag
    ,input  logic        deq_underrun
    ,input  logic        pwr_ack_b
    ,input  list_cnt_t   list_count
    ,input  logic        step_chk
    ,input  list_cnt_t   exp_count
    ,output int          error_count
);

    // Model state as it should look after the most recent rising edge
    list_entry_t model_q [$];
    int          m_count;
    logic        m_ack;
    logic        m_drop;
    logic        m_miss;
    logic        m_underrun;
    logic        m_valid;
    logic        ready = 1'b0;
    logic        enq_ok;
    logic        pop;

    // Read pipeline, stage one after the pop and stage two after the array read
    logic        s1_v;
    logic        s2_v;
    list_entry_t s1_d;
    list_entry_t s2_d;
    list_entry_t out_d;

    initial error_count = 0;

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
        error_count++;
    endtask

    // Outputs and inputs are both settled on the falling edge
    always @(negedge clk) begin
        if (ready) begin
            if (list_count != list_cnt_t'(m_count))
                report_mismatch("list_count", int'(list_count), m_count);
            if (pwr_ack_b != m_ack)
                report_mismatch("pwr_ack_b", int'(pwr_ack_b), int'(m_ack));
            if (enq_drop != m_drop)
                report_mismatch("enq_drop", int'(enq_drop), int'(m_drop));
            if (deq_underrun != m_underrun)
                report_mismatch("deq_underrun", int'(deq_underrun), int'(m_underrun));
            if (deq_valid != m_valid)
                report_mismatch("deq_valid", int'(deq_valid), int'(m_valid));
            else if (m_valid && ({deq_qid, deq_tag} != out_d))
                report_mismatch("dequeued entry", int'({deq_qid, deq_tag}), int'(out_d));
            if (step_chk && (list_count != exp_count))
                report_mismatch("list_count at step end", int'(list_count), int'(exp_count));
        end

        // Advance the model with the inputs the next rising edge will sample
        if (!rst_n) begin
            model_q.delete();
            m_count    = 0;
            m_ack      = 1'b1;
            m_drop     = 1'b0;
            m_miss     = 1'b0;
            m_underrun = 1'b0;
            m_valid    = 1'b0;
            s1_v       = 1'b0;
            s2_v       = 1'b0;
            ready      = 1'b1;
        end else begin
            enq_ok = enq_valid && (m_count < `LIST_DEPTH) && !m_ack;
            pop    = deq_req && (m_count != 0);
            // Captured data is zero under isolation, and a sleeping array reads zero
            m_valid = s2_v;
            out_d   = isol_en ? '0 : s2_d;
            s2_v    = s1_v;
            s2_d    = m_ack ? '0 : s1_d;
            s1_v    = pop;
            if (pop)
                s1_d = model_q.pop_front();
            m_underrun = m_miss;
            m_miss     = deq_req && (m_count == 0);
            m_drop     = enq_valid && !enq_ok;
            if (m_ack) begin
                model_q.delete();
            end else if (enq_ok) begin
                model_q.push_back({enq_qid, enq_tag});
            end
            m_count = model_q.size();
            m_ack   = pwr_enable_b;
        end
    end

endmodule

//--- verification/list_mem_tb.sv
//------------------------------
// List storage testbench
// Drives the list memory top through a table of steps covering
// in-order read-back, full and empty lists, simultaneous traffic,
// sleep and wake, and isolation. The watcher module does the checks
//------------------------------
`timescale 1ns/1ps
`include "list_mem_macros.svh"

module list_mem_tb
    import list_mem_pkg::*;
();

    typedef enum logic [2:0] {OP_ENQ, OP_DEQ, OP_BOTH, OP_SLEEP, OP_WAKE, OP_ISO, OP_IDLE} op_t;

    // One table row, the count column is the list_count expected after the step
    typedef struct packed {
        op_t        op;
        list_qid_t  qid;
        list_tag_t  tag;
        logic [5:0] reps;
        list_cnt_t  exp_cnt;
    } step_t;

    localparam int NSTEPS = 22;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enq_valid;
    list_qid_t   enq_qid;
    list_tag_t   enq_tag;
    logic        enq_drop;
    logic        deq_req;
    logic        deq_valid;
    list_qid_t   deq_qid;
    list_tag_t   deq_tag;
    logic        deq_underrun;
    logic        pwr_enable_b;
    logic        pwr_ack_b;
    logic        isol_en;
    list_cnt_t   list_count;
    logic        step_chk;
    list_cnt_t   exp_count;
    int          errors;
    integer      seed;

    // Fill steps (more than one repeat on enqueue) take random tags
    step_t steps [NSTEPS] = '{
        '{OP_WAKE,  5'd0,  9'h000, 6'd1,  6'd0},
        '{OP_DEQ,   5'd0,  9'h000, 6'd1,  6'd0},
        '{OP_ENQ,   5'd3,  9'h055, 6'd1,  6'd1},
        '{OP_ENQ,   5'd4,  9'h1aa, 6'd1,  6'd2},
        '{OP_DEQ,   5'd0,  9'h000, 6'd2,  6'd0},
        '{OP_ENQ,   5'd0,  9'h000, 6'd32, 6'd32},
        '{OP_ENQ,   5'd9,  9'h123, 6'd1,  6'd32},
        '{OP_DEQ,   5'd0,  9'h000, 6'd4,  6'd28},
        '{OP_BOTH,  5'd16, 9'h000, 6'd10, 6'd28},
        '{OP_DEQ,   5'd0,  9'h000, 6'd28, 6'd0},
        '{OP_DEQ,   5'd0,  9'h000, 6'd1,  6'd0},
        '{OP_ENQ,   5'd5,  9'h000, 6'd3,  6'd3},
        '{OP_SLEEP, 5'd0,  9'h000, 6'd2,  6'd0},
        '{OP_ENQ,   5'd6,  9'h000, 6'd2,  6'd0},
        '{OP_DEQ,   5'd0,  9'h000, 6'd1,  6'd0},
        '{OP_WAKE,  5'd0,  9'h000, 6'd2,  6'd0},
        '{OP_ENQ,   5'd7,  9'h000, 6'd2,  6'd2},
        '{OP_DEQ,   5'd0,  9'h000, 6'd2,  6'd0},
        '{OP_ENQ,   5'd8,  9'h000, 6'd2,  6'd2},
        '{OP_ISO,   5'd0,  9'h000, 6'd1,  6'd1},
        '{OP_DEQ,   5'd0,  9'h000, 6'd1,  6'd0},
        '{OP_IDLE,  5'd0,  9'h000, 6'd4,  6'd0}
    };

    always #20 clk = ~clk;

    //------------------------------
    // DUT and watcher

    list_mem_top UUT (
         .clk(clk), .rst_n(rst_n)
        ,.enq_valid(enq_valid), .enq_qid(enq_qid), .enq_tag(enq_tag), .enq_drop(enq_drop)
        ,.deq_req(deq_req), .deq_valid(deq_valid), .deq_qid(deq_qid), .deq_tag(deq_tag)
        ,.deq_underrun(deq_underrun)
        ,.pwr_enable_b(pwr_enable_b), .pwr_ack_b(pwr_ack_b), .isol_en(isol_en)
        ,.list_count(list_count)
    );

    list_mem_checker watcher (
         .clk(clk), .rst_n(rst_n)
        ,.enq_valid(enq_valid), .enq_qid(enq_qid), .enq_tag(enq_tag)
        ,.deq_req(deq_req), .pwr_enable_b(pwr_enable_b), .isol_en(isol_en)
        ,.enq_drop(enq_drop), .deq_valid(deq_valid), .deq_qid(deq_qid), .deq_tag(deq_tag)
        ,.deq_underrun(deq_underrun), .pwr_ack_b(pwr_ack_b), .list_count(list_count)
        ,.step_chk(step_chk), .exp_count(exp_count), .error_count(errors)
    );

    // Drive one cycle of a step, active is low in the isolation hold cycles
    task automatic apply_op(input step_t st, input logic active, input int idx);
        logic [31:0] rnd;
        enq_valid <= 1'b0;
        deq_req   <= 1'b0;
        step_chk  <= 1'b0;
        case (st.op)
            OP_ENQ, OP_BOTH: begin
                enq_valid <= 1'b1;
                enq_qid   <= st.qid + list_qid_t'(idx);
                if (st.reps > 6'd1) begin
                    rnd = $random(seed);
                    enq_tag <= rnd[8:0];
                end else begin
                    enq_tag <= st.tag;
                end
                deq_req <= (st.op == OP_BOTH);
            end
            OP_DEQ:   deq_req <= 1'b1;
            OP_SLEEP: pwr_enable_b <= 1'b1;
            OP_WAKE:  pwr_enable_b <= 1'b0;
            // Isolation stays on until the read has been captured
            OP_ISO: begin
                isol_en <= 1'b1;
                deq_req <= active;
            end
            default: begin
            end
        endcase
    endtask

    //------------------------------
    // Stimulus

    initial begin : stimulus
        int r;
        int hold;
        seed         = 32'h3f36;
        rst_n        = 1'b0;
        enq_valid    = 1'b0;
        enq_qid      = '0;
        enq_tag      = '0;
        deq_req      = 1'b0;
        pwr_enable_b = 1'b1;
        isol_en      = 1'b0;
        step_chk     = 1'b0;
        exp_count    = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[s]) begin
            hold = (steps[s].op == OP_ISO) ? 2 : 0;
            for (r = 0; r < int'(steps[s].reps) + hold; r++) begin
                @(posedge clk);
                apply_op(steps[s], r < int'(steps[s].reps), r);
            end
            // Closing cycle of the step, the watcher compares the count after it
            @(posedge clk);
            enq_valid <= 1'b0;
            deq_req   <= 1'b0;
            isol_en   <= 1'b0;
            step_chk  <= 1'b1;
            exp_count <= steps[s].exp_cnt;
        end
        @(posedge clk);
        step_chk <= 1'b0;
        // Dequeue latency is two cycles, so a short drain is enough
        repeat (4) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    //------------------------------
    // Watchdog

    initial begin : watchdog
        int limit;
        limit = 0;
        foreach (steps[i])
            limit += int'(steps[i].reps) + 3;
        limit = limit * 4 + 200 + 10;
        repeat (limit) @(posedge clk);
        $display("Timeout: the stimulus table did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/list_mem_pkg.sv
logic/list_enq.sv
logic/list_rf_pg_32x14.sv
logic/list_deq.sv
logic/list_mem_top.sv
verification/list_mem_checker.sv
verification/list_mem_tb.sv

//--- Makefile
# Verilator build and run for the list storage testbench

VERILATOR ?= verilator
TOP       ?= list_mem_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if ! grep -q "TB PASSED" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
